// ==== hw/adc_pif_macros.svh ====
// **************************************************
// adc parallel port controller shared constants
// bus width, strobe lengths and register addresses
// **************************************************

`ifndef ADC_PIF_MACROS_SVH
`define ADC_PIF_MACROS_SVH

// width of the converter data bus in bits
`define DB_WIDTH 16

// cycles that convert-start stays low
`define CNV_LOW_CYCLES 2

// cycles that chip select and read strobe stay low for one word
`define RD_LOW_CYCLES 2

// cycles that chip select and write strobe stay low
`define WR_LOW_CYCLES 2

// the low two data bits written here select the frame mode
`define CFG_MODE_ADDR 2

// the longest frame holds eight channel pairs plus the status word
`define MAX_CHS 17

`endif

// ==== hw/adc_pif_pkg.sv ====
// **************************************************
// adc parallel port controller types
// bus operation, frame mode and channel index
// **************************************************

`default_nettype none

package adc_pif_pkg;

    // operation carried by a bus request
    // idle is driven whenever the requester has nothing pending
    typedef enum logic [1:0] {
        BUS_IDLE  = 2'd0,
        BUS_READ  = 2'd1,
        BUS_WRITE = 2'd2
    } bus_op_e;

    // frame mode as held in the configuration register
    // the 9 and 17 word modes append one status word after the channels
    typedef enum logic [1:0] {
        MODE_8CH  = 2'd0,
        MODE_9CH  = 2'd1,
        MODE_16CH = 2'd2,
        MODE_17CH = 2'd3
    } frame_mode_e;

    // position of a word within a frame
    // five bits cover the 17 word frame
    typedef logic [4:0] ch_idx_t;

endpackage

`default_nettype wire

// ==== hw/pbus_if.sv ====
// **************************************************
// parallel bus request channel
// joins one requester to the bus arbiter
// **************************************************

`timescale 1ns/100ps
`default_nettype none

`include "adc_pif_macros.svh"

interface pbus_if;

    import adc_pif_pkg::*;

    // request is held together with op and wdata until done
    logic                 req;
    bus_op_e              op;
    logic [`DB_WIDTH-1:0] wdata;

    // done is a one cycle pulse at the end of the transaction
    // on a read rdata holds the captured word in that same cycle
    logic [`DB_WIDTH-1:0] rdata;
    logic                 done;

    // side that asks for the bus
    modport requester (
        output req, op, wdata,
        input  rdata, done
    );

    // side that owns the pins and answers the request
    modport arbiter (
        input  req, op, wdata,
        output rdata, done
    );

endinterface

`default_nettype wire

// ==== hw/pbus_arbiter.sv ====
// **************************************************
// parallel bus arbiter
// grants the shared adc bus per transaction and
// drives chip select, read, write and tristate
// **************************************************

`timescale 1ns/100ps
`default_nettype none

`include "adc_pif_macros.svh"

module pbus_arbiter (
    input  wire                 sys_clk,
    input  wire                 rst_n_i,
    pbus_if.arbiter             seq_bus,
    pbus_if.arbiter             cfg_bus,
    input  wire [`DB_WIDTH-1:0] adc_db_i,
    output logic                adc_cs_n_o,
    output logic                adc_rd_n_o,
    output logic                adc_wr_n_o,
    output logic                adc_db_t_o,
    output logic [`DB_WIDTH-1:0] adc_db_o
);

    import adc_pif_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STROBE,
        ST_RELEASE
    } arb_state_e;

    arb_state_e           state_q;
    // the grant register keeps its value after a transaction and so
    // also remembers who was served last
    logic                 gnt_cfg_q;
    logic [2:0]           cnt_q;
    logic [`DB_WIDTH-1:0] rdata_q;

    logic                 pick_cfg;
    logic                 any_req;
    logic                 cur_cfg;
    bus_op_e              cur_op;
    logic                 is_write;
    logic [2:0]           low_last;
    logic                 done;

    // **************************************************
    // request selection
    // **************************************************

    assign any_req  = seq_bus.req | cfg_bus.req;
    // on contention the requester not served last time wins
    assign pick_cfg = cfg_bus.req & (~seq_bus.req | ~gnt_cfg_q);

    // while idle the pins follow the pending winner, otherwise the held grant
    assign cur_cfg  = (state_q == ST_IDLE) ? pick_cfg : gnt_cfg_q;
    assign cur_op   = cur_cfg ? cfg_bus.op : seq_bus.op;
    assign is_write = (cur_op == BUS_WRITE);
    assign adc_db_o = cur_cfg ? cfg_bus.wdata : seq_bus.wdata;

    assign low_last = is_write ? 3'(`WR_LOW_CYCLES - 1) : 3'(`RD_LOW_CYCLES - 1);

    // **************************************************
    // transaction state machine
    // **************************************************

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= ST_IDLE;
            gnt_cfg_q <= 1'b0;
            cnt_q     <= 3'd0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    // a grant is only ever given from the idle bus
                    if (any_req) begin
                        state_q   <= ST_STROBE;
                        gnt_cfg_q <= pick_cfg;
                        cnt_q     <= 3'd0;
                    end
                end
                ST_STROBE: begin
                    if (cnt_q == low_last) begin
                        state_q <= ST_RELEASE;
                        cnt_q   <= 3'd0;
                    end else begin
                        cnt_q <= cnt_q + 3'd1;
                    end
                end
                ST_RELEASE: begin
                    // a read releases in one cycle, a write keeps the
                    // data driven for one more cycle after wr_n rises
                    if (done) begin
                        state_q <= ST_IDLE;
                        cnt_q   <= 3'd0;
                    end else begin
                        cnt_q <= cnt_q + 3'd1;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // the word is sampled in the last low cycle of the read strobe
    always_ff @(posedge sys_clk) begin
        if (state_q == ST_STROBE && cnt_q == low_last && !is_write) begin
            rdata_q <= adc_db_i;
        end
    end

    assign done = (state_q == ST_RELEASE) && (!is_write || cnt_q == 3'd1);

    // **************************************************
    // pin and handshake outputs
    // **************************************************

    assign adc_cs_n_o = ~(state_q == ST_STROBE);
    assign adc_rd_n_o = ~(state_q == ST_STROBE && !is_write);
    assign adc_wr_n_o = ~(state_q == ST_STROBE && is_write);

    // the bus is driven from the grant until one cycle after wr_n rises
    assign adc_db_t_o = ~(is_write && ((state_q == ST_IDLE && any_req) ||
                                       state_q == ST_STROBE ||
                                       (state_q == ST_RELEASE && cnt_q == 3'd0)));

    assign seq_bus.done  = done & ~gnt_cfg_q;
    assign cfg_bus.done  = done & gnt_cfg_q;
    assign seq_bus.rdata = rdata_q;
    assign cfg_bus.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== hw/conv_sequencer.sv ====
// **************************************************
// conversion sequencer
// starts a conversion, waits out busy and reads
// every word of the frame over the shared bus
// **************************************************

`timescale 1ns/100ps
`default_nettype none

`include "adc_pif_macros.svh"

module conv_sequencer (
    input  wire                      sys_clk,
    input  wire                      rst_n_i,
    input  wire                      conv_start_i,
    input  wire adc_pif_pkg::frame_mode_e frame_mode_i,
    input  wire                      adc_busy_i,
    output logic                     adc_cnvst_n_o,
    pbus_if.requester                bus,
    output logic                     sample_valid_o,
    output logic                     frame_done_o,
    output adc_pif_pkg::ch_idx_t     sample_ch_o,
    output logic [`DB_WIDTH-1:0]     sample_data_o
);

    import adc_pif_pkg::*;

    typedef enum logic [2:0] {
        SQ_IDLE,
        SQ_CNV,
        SQ_WAIT_HI,
        SQ_WAIT_LO,
        SQ_READ
    } seq_state_e;

    seq_state_e state_q;
    logic [2:0] cnv_cnt_q;
    ch_idx_t    ch_cnt_q;
    ch_idx_t    last_ch_q;
    ch_idx_t    mode_last;
    logic       req_q;
    logic       busy_meta_q;
    logic       busy_sync_q;
    logic       valid_q;
    logic       frame_done_q;

    // index of the final word for each frame mode
    always_comb begin
        case (frame_mode_i)
            MODE_8CH:  mode_last = ch_idx_t'(7);
            MODE_9CH:  mode_last = ch_idx_t'(8);
            MODE_16CH: mode_last = ch_idx_t'(15);
            MODE_17CH: mode_last = ch_idx_t'(`MAX_CHS - 1);
            default:   mode_last = ch_idx_t'(7);
        endcase
    end

    // busy comes straight from the converter pin and is not related to sys_clk
    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_meta_q <= 1'b0;
            busy_sync_q <= 1'b0;
        end else begin
            busy_meta_q <= adc_busy_i;
            busy_sync_q <= busy_meta_q;
        end
    end

    // **************************************************
    // frame sequencing
    // **************************************************

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= SQ_IDLE;
            cnv_cnt_q    <= 3'd0;
            ch_cnt_q     <= '0;
            last_ch_q    <= '0;
            req_q        <= 1'b0;
            valid_q      <= 1'b0;
            frame_done_q <= 1'b0;
        end else begin
            valid_q      <= 1'b0;
            frame_done_q <= 1'b0;
            case (state_q)
                SQ_IDLE: begin
                    // the mode in force now sets the length of the whole frame
                    if (conv_start_i) begin
                        state_q   <= SQ_CNV;
                        cnv_cnt_q <= 3'd0;
                        last_ch_q <= mode_last;
                    end
                end
                SQ_CNV: begin
                    if (cnv_cnt_q == 3'(`CNV_LOW_CYCLES - 1)) begin
                        state_q <= SQ_WAIT_HI;
                    end else begin
                        cnv_cnt_q <= cnv_cnt_q + 3'd1;
                    end
                end
                SQ_WAIT_HI: begin
                    // busy may already be up by now, so the level is enough here
                    if (busy_sync_q) begin
                        state_q <= SQ_WAIT_LO;
                    end
                end
                SQ_WAIT_LO: begin
                    // conversion results are ready once busy falls
                    if (!busy_sync_q) begin
                        state_q  <= SQ_READ;
                        req_q    <= 1'b1;
                        ch_cnt_q <= '0;
                    end
                end
                SQ_READ: begin
                    if (bus.done) begin
                        valid_q <= 1'b1;
                        if (ch_cnt_q == last_ch_q) begin
                            req_q        <= 1'b0;
                            frame_done_q <= 1'b1;
                            state_q      <= SQ_IDLE;
                        end else begin
                            ch_cnt_q <= ch_cnt_q + ch_idx_t'(1);
                        end
                    end
                end
                default: begin
                    state_q <= SQ_IDLE;
                end
            endcase
        end
    end

    // the word and its index follow each read done by one cycle
    always_ff @(posedge sys_clk) begin
        if (bus.done) begin
            sample_data_o <= bus.rdata;
            sample_ch_o   <= ch_cnt_q;
        end
    end

    assign adc_cnvst_n_o  = ~(state_q == SQ_CNV);
    assign sample_valid_o = valid_q;
    assign frame_done_o   = frame_done_q;

    // reads are requested back to back until the last word
    assign bus.req   = req_q;
    assign bus.op    = req_q ? BUS_READ : BUS_IDLE;
    assign bus.wdata = '0;

endmodule

`default_nettype wire

// ==== hw/cfg_writer.sv ====
// **************************************************
// configuration writer
// turns a configuration strobe into a bus write and
// keeps the frame mode register
// **************************************************

`timescale 1ns/100ps
`default_nettype none

`include "adc_pif_macros.svh"

module cfg_writer (
    input  wire                      sys_clk,
    input  wire                      rst_n_i,
    input  wire                      cfg_wr_i,
    input  wire [6:0]                cfg_addr_i,
    input  wire [7:0]                cfg_data_i,
    pbus_if.requester                bus,
    output adc_pif_pkg::frame_mode_e frame_mode_o
);

    import adc_pif_pkg::*;

    logic                 pending_q;
    logic [`DB_WIDTH-1:0] wdata_q;
    frame_mode_e          mode_q;
    logic                 mode_hit;

    // address field of the held word selects the mode register
    assign mode_hit = (wdata_q[14:8] == 7'(`CFG_MODE_ADDR));

    // control part of the writer
    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q <= 1'b0;
            mode_q    <= MODE_8CH;
        end else begin
            if (pending_q) begin
                // strobes seen while a write is outstanding are dropped
                if (bus.done) begin
                    pending_q <= 1'b0;
                    if (mode_hit) begin
                        mode_q <= frame_mode_e'(wdata_q[1:0]);
                    end
                end
            end else if (cfg_wr_i) begin
                pending_q <= 1'b1;
            end
        end
    end

    // write word is a zero bit, the seven bit address and the data byte
    always_ff @(posedge sys_clk) begin
        if (cfg_wr_i && !pending_q) begin
            wdata_q <= {1'b0, cfg_addr_i, cfg_data_i};
        end
    end

    assign bus.req      = pending_q;
    assign bus.op       = pending_q ? BUS_WRITE : BUS_IDLE;
    assign bus.wdata    = wdata_q;
    assign frame_mode_o = mode_q;

endmodule

`default_nettype wire

// ==== hw/adc_pif_top.sv ====
// **************************************************
// adc parallel port controller top level
// sequencer and config writer share the bus arbiter
// **************************************************

`timescale 1ns/100ps
`default_nettype none

`include "adc_pif_macros.svh"

module adc_pif_top (
    input  wire                  sys_clk,
    input  wire                  rst_n_i,
    // control strobes
    input  wire                  conv_start_i,
    input  wire                  cfg_wr_i,
    input  wire [6:0]            cfg_addr_i,
    input  wire [7:0]            cfg_data_i,
    // sample stream
    output logic                 sample_valid_o,
    output adc_pif_pkg::ch_idx_t sample_ch_o,
    output logic [`DB_WIDTH-1:0] sample_data_o,
    output logic                 frame_done_o,
    // converter pins
    output logic                 adc_cnvst_n_o,
    input  wire                  adc_busy_i,
    output logic                 adc_cs_n_o,
    output logic                 adc_rd_n_o,
    output logic                 adc_wr_n_o,
    input  wire [`DB_WIDTH-1:0]  adc_db_i,
    output logic [`DB_WIDTH-1:0] adc_db_o,
    output logic                 adc_db_t_o
);

    import adc_pif_pkg::*;

    // one request channel per bus user
    pbus_if seq_bus ();
    pbus_if cfg_bus ();

    // mode held by the writer and sampled by the sequencer at frame start
    frame_mode_e frame_mode;

    conv_sequencer u_seq (
        .sys_clk        (sys_clk),
        .rst_n_i        (rst_n_i),
        .conv_start_i   (conv_start_i),
        .frame_mode_i   (frame_mode),
        .adc_busy_i     (adc_busy_i),
        .adc_cnvst_n_o  (adc_cnvst_n_o),
        .bus            (seq_bus),
        .sample_valid_o (sample_valid_o),
        .frame_done_o   (frame_done_o),
        .sample_ch_o    (sample_ch_o),
        .sample_data_o  (sample_data_o)
    );

    cfg_writer u_cfg (
        .sys_clk      (sys_clk),
        .rst_n_i      (rst_n_i),
        .cfg_wr_i     (cfg_wr_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_data_i   (cfg_data_i),
        .bus          (cfg_bus),
        .frame_mode_o (frame_mode)
    );

    // the arbiter is the only block that touches the shared pins
    pbus_arbiter u_arb (
        .sys_clk    (sys_clk),
        .rst_n_i    (rst_n_i),
        .seq_bus    (seq_bus),
        .cfg_bus    (cfg_bus),
        .adc_db_i   (adc_db_i),
        .adc_cs_n_o (adc_cs_n_o),
        .adc_rd_n_o (adc_rd_n_o),
        .adc_wr_n_o (adc_wr_n_o),
        .adc_db_t_o (adc_db_t_o),
        .adc_db_o   (adc_db_o)
    );

endmodule

`default_nettype wire

// ==== test/adc_model.sv ====
// **************************************************
// behavioral parallel port adc model
// answers convert-start with busy and reads with
// words patterned by conversion count and channel
// **************************************************

`timescale 1ns/100ps
`default_nettype none

`include "adc_pif_macros.svh"

module adc_model (
    input  wire                  sys_clk,
    input  wire                  rst_n_i,
    input  wire                  cnvst_n_i,
    input  wire                  cs_n_i,
    input  wire                  rd_n_i,
    input  wire                  wr_n_i,
    input  wire                  db_t_i,
    input  wire [`DB_WIDTH-1:0]  db_i,
    output logic                 busy_o,
    output logic [`DB_WIDTH-1:0] db_o
);

    integer     seed = 32'h6d071628;
    integer     busy_left;
    logic       cnv_prev;
    logic       rd_prev;
    logic       start_q;
    logic [7:0] conv_cnt;
    logic [1:0] cur_mode;
    logic [1:0] conv_mode;
    logic [4:0] ptr;
    logic [4:0] status_idx;

    // the status word closes the 9 and 17 word frames, other modes have none
    assign status_idx = (conv_mode == 2'd1) ? 5'd8 :
                        (conv_mode == 2'd3) ? 5'd16 : 5'd31;

    always @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnv_prev  <= 1'b1;
            rd_prev   <= 1'b1;
            start_q   <= 1'b0;
            busy_o    <= 1'b0;
            busy_left <= 0;
            conv_cnt  <= 8'd0;
            cur_mode  <= 2'd0;
            conv_mode <= 2'd0;
            ptr       <= 5'd0;
            db_o      <= '0;
        end else begin
            cnv_prev <= cnvst_n_i;
            rd_prev  <= rd_n_i;
            // a new conversion rewinds the channel pointer and freezes the mode
            if (cnv_prev && !cnvst_n_i) begin
                start_q   <= 1'b1;
                conv_cnt  <= conv_cnt + 8'd1;
                conv_mode <= cur_mode;
                ptr       <= 5'd0;
            end
            // busy rises two cycles after the falling edge of convert-start
            if (start_q) begin
                start_q   <= 1'b0;
                busy_o    <= 1'b1;
                busy_left <= 3 + ({$random(seed)} % 8);
            end else if (busy_o) begin
                if (busy_left == 1) begin
                    busy_o <= 1'b0;
                end
                busy_left <= busy_left - 1;
            end
            // each read strobe hands out the next word of the frame
            if (rd_prev && !rd_n_i && !cs_n_i) begin
                db_o <= (ptr == status_idx) ? 16'h5A00 + conv_cnt : {conv_cnt, 3'b000, ptr};
                ptr  <= ptr + 5'd1;
            end
            // the model snoops mode writes just as the real device would latch them
            if (!wr_n_i && !cs_n_i && !db_t_i && db_i[14:8] == 7'(`CFG_MODE_ADDR)) begin
                cur_mode <= db_i[1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_adc_pif.sv ====
// **************************************************
// testbench for the adc parallel port controller
// runs a table of writes and conversions against
// the behavioral adc model
// **************************************************

`timescale 1ns/100ps
`default_nettype none

`include "adc_pif_macros.svh"

module tb_adc_pif;

    localparam int OP_WR       = 0;
    localparam int OP_CNV      = 1;
    localparam int OP_MIX      = 2;
    localparam int NUM_ENTRIES = 15;

    logic                 sys_clk;
    logic                 rst_n_i;
    logic                 conv_start_i;
    logic                 cfg_wr_i;
    logic [6:0]           cfg_addr_i;
    logic [7:0]           cfg_data_i;
    logic                 sample_valid_o;
    logic                 frame_done_o;
    logic [4:0]           sample_ch_o;
    logic [`DB_WIDTH-1:0] sample_data_o;
    logic                 adc_cnvst_n_o;
    logic                 adc_busy_i;
    logic                 adc_cs_n_o;
    logic                 adc_rd_n_o;
    logic                 adc_wr_n_o;
    logic                 adc_db_t_o;
    logic [`DB_WIDTH-1:0] adc_db_i;
    logic [`DB_WIDTH-1:0] adc_db_o;

    // test table with one operation per entry
    int         op_tab   [NUM_ENTRIES];
    logic [6:0] addr_tab [NUM_ENTRIES];
    logic [7:0] data_tab [NUM_ENTRIES];
    int         len_tab  [NUM_ENTRIES];

    // observations gathered by the monitor
    int          errors;
    int          wr_pulses;
    int          wr_bad;
    int          cnv_pulses;
    int          frames;
    logic [15:0] wr_word;
    logic        wr_prev;
    logic        cnv_prev;
    logic [4:0]  ch_q   [$];
    logic [15:0] data_q [$];
    logic        fd_q   [$];
    logic [7:0]  conv_no;

    adc_pif_top uut (
        .sys_clk        (sys_clk),
        .rst_n_i        (rst_n_i),
        .conv_start_i   (conv_start_i),
        .cfg_wr_i       (cfg_wr_i),
        .cfg_addr_i     (cfg_addr_i),
        .cfg_data_i     (cfg_data_i),
        .sample_valid_o (sample_valid_o),
        .sample_ch_o    (sample_ch_o),
        .sample_data_o  (sample_data_o),
        .frame_done_o   (frame_done_o),
        .adc_cnvst_n_o  (adc_cnvst_n_o),
        .adc_busy_i     (adc_busy_i),
        .adc_cs_n_o     (adc_cs_n_o),
        .adc_rd_n_o     (adc_rd_n_o),
        .adc_wr_n_o     (adc_wr_n_o),
        .adc_db_i       (adc_db_i),
        .adc_db_o       (adc_db_o),
        .adc_db_t_o     (adc_db_t_o)
    );

    adc_model u_adc (
        .sys_clk   (sys_clk),
        .rst_n_i   (rst_n_i),
        .cnvst_n_i (adc_cnvst_n_o),
        .cs_n_i    (adc_cs_n_o),
        .rd_n_i    (adc_rd_n_o),
        .wr_n_i    (adc_wr_n_o),
        .db_t_i    (adc_db_t_o),
        .db_i      (adc_db_o),
        .busy_o    (adc_busy_i),
        .db_o      (adc_db_i)
    );

    always #4 sys_clk = ~sys_clk;

    // **************************************************
    // the monitor samples on the falling edge where all
    // outputs are settled
    // **************************************************

    always @(negedge sys_clk) begin
        if (rst_n_i) begin
            if (sample_valid_o) begin
                ch_q.push_back(sample_ch_o);
                data_q.push_back(sample_data_o);
                fd_q.push_back(frame_done_o);
            end
            if (frame_done_o) begin
                frames = frames + 1;
            end
            if (!adc_wr_n_o && wr_prev) begin
                wr_pulses = wr_pulses + 1;
                wr_word   = adc_db_o;
            end
            // the data must be driven and steady over the whole write strobe
            if (!adc_wr_n_o && (adc_db_t_o || adc_db_o != wr_word)) begin
                wr_bad = wr_bad + 1;
            end
            if (!adc_cnvst_n_o && cnv_prev) begin
                cnv_pulses = cnv_pulses + 1;
            end
        end
        wr_prev  = adc_wr_n_o;
        cnv_prev = adc_cnvst_n_o;
    end

    // the run is bounded by 200 cycles per table entry
    initial begin
        #(NUM_ENTRIES * 200 * 8 + 200);
        $display("Watchdog expired at %0t ns before the table was done", $time);
        $display("ERRORS FOUND");
        $finish;
    end

    // **************************************************
    // helpers
    // **************************************************

    task automatic set_entry(input int idx, input int op, input logic [6:0] addr,
                             input logic [7:0] data, input int len);
        op_tab[idx]   = op;
        addr_tab[idx] = addr;
        data_tab[idx] = data;
        len_tab[idx]  = len;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
        errors = errors + 1;
    endtask

    // one cycle strobes are driven on the falling edge
    task automatic drive_strobes(input logic cnv, input logic wr, input logic [6:0] addr,
                                 input logic [7:0] data);
        @(negedge sys_clk);
        conv_start_i = cnv;
        cfg_wr_i     = wr;
        cfg_addr_i   = addr;
        cfg_data_i   = data;
        @(negedge sys_clk);
        conv_start_i = 1'b0;
        cfg_wr_i     = 1'b0;
    endtask

    task automatic wait_frame_end(input int start);
        int n;
        n = 0;
        while (frames == start && n < 400) begin
            @(posedge sys_clk);
            n = n + 1;
        end
        if (frames == start) begin
            $display("Frame did not end within 400 cycles at %0t ns", $time);
            errors = errors + 1;
        end
    endtask

    task automatic wait_write_pulse(input int start);
        int n;
        n = 0;
        while (wr_pulses == start && n < 100) begin
            @(posedge sys_clk);
            n = n + 1;
        end
        if (wr_pulses == start) begin
            $display("No write strobe seen within 100 cycles at %0t ns", $time);
            errors = errors + 1;
        end
    endtask

    task automatic wait_samples(input int count);
        int n;
        n = 0;
        while (ch_q.size() < count && n < 200) begin
            @(posedge sys_clk);
            n = n + 1;
        end
    endtask

    // channel words carry the conversion count over the index,
    // the last word of a 9 or 17 word frame is the status word
    function automatic logic [15:0] expected_word(input logic [7:0] conv, input int idx,
                                                  input int len);
        if ((len == 9 || len == 17) && idx == len - 1) begin
            return 16'h5A00 + conv;
        end
        return {conv, idx[7:0]};
    endfunction

    task automatic check_frame(input int len, input logic [7:0] conv);
        int i;
        if (ch_q.size() != len) begin
            report_mismatch("frame length", ch_q.size(), len);
        end
        for (i = 0; i < ch_q.size() && i < len; i++) begin
            if (ch_q[i] != i[4:0]) begin
                report_mismatch("sample_ch_o", ch_q[i], i);
            end
            if (data_q[i] != expected_word(conv, i, len)) begin
                report_mismatch("sample_data_o", data_q[i], expected_word(conv, i, len));
            end
            if (fd_q[i] != (i == len - 1)) begin
                report_mismatch("frame_done_o", fd_q[i], (i == len - 1));
            end
        end
    endtask

    task automatic check_write(input int start, input logic [6:0] addr, input logic [7:0] data);
        if (wr_pulses != start + 1) begin
            report_mismatch("adc_wr_n_o pulse count", wr_pulses - start, 1);
        end
        if (wr_word != {1'b0, addr, data}) begin
            report_mismatch("adc_db_o", wr_word, {1'b0, addr, data});
        end
        if (wr_bad != 0) begin
            $display("Error at %0t ns: write data was not held on the bus during wr_n low",
                     $time);
            errors = errors + 1;
            wr_bad = 0;
        end
    endtask

    // **************************************************
    // stimulus
    // **************************************************

    initial begin
        int i;
        int wr0;
        int cnv0;
        int fr0;
        sys_clk      = 1'b0;
        rst_n_i      = 1'b0;
        conv_start_i = 1'b0;
        cfg_wr_i     = 1'b0;
        cfg_addr_i   = 7'd0;
        cfg_data_i   = 8'd0;
        conv_no      = 8'd0;
        errors       = 0;
        // mode writes at address 2, one write elsewhere, and two frames with
        // a write and a stray start slipped in while reads are running
        set_entry(0, OP_CNV, 7'd0, 8'h00, 8);
        set_entry(1, OP_WR, 7'd2, 8'h01, 0);
        set_entry(2, OP_CNV, 7'd0, 8'h00, 9);
        set_entry(3, OP_WR, 7'd2, 8'h02, 0);
        set_entry(4, OP_CNV, 7'd0, 8'h00, 16);
        set_entry(5, OP_WR, 7'd2, 8'h03, 0);
        set_entry(6, OP_CNV, 7'd0, 8'h00, 17);
        set_entry(7, OP_WR, 7'd5, 8'h02, 0);
        set_entry(8, OP_CNV, 7'd0, 8'h00, 17);
        set_entry(9, OP_WR, 7'd2, 8'h00, 0);
        set_entry(10, OP_CNV, 7'd0, 8'h00, 8);
        set_entry(11, OP_MIX, 7'd2, 8'h01, 8);
        set_entry(12, OP_CNV, 7'd0, 8'h00, 9);
        set_entry(13, OP_MIX, 7'd2, 8'h03, 9);
        set_entry(14, OP_CNV, 7'd0, 8'h00, 17);

        repeat (3) @(posedge sys_clk);
        @(negedge sys_clk);
        rst_n_i = 1'b1;
        repeat (3) @(posedge sys_clk);
        @(negedge sys_clk);

        // all pins idle and no strobes before any stimulus
        if ({adc_cnvst_n_o, adc_cs_n_o, adc_rd_n_o, adc_wr_n_o, adc_db_t_o} != 5'b11111) begin
            report_mismatch("idle control pins",
                            {adc_cnvst_n_o, adc_cs_n_o, adc_rd_n_o, adc_wr_n_o, adc_db_t_o},
                            5'b11111);
        end
        if (sample_valid_o || frame_done_o || ch_q.size() != 0) begin
            $display("Error at %0t ns: sample strobe seen before any stimulus", $time);
            errors = errors + 1;
        end

        for (i = 0; i < NUM_ENTRIES; i++) begin
            wr0  = wr_pulses;
            cnv0 = cnv_pulses;
            fr0  = frames;
            ch_q.delete();
            data_q.delete();
            fd_q.delete();
            if (op_tab[i] == OP_WR) begin
                drive_strobes(1'b0, 1'b1, addr_tab[i], data_tab[i]);
                wait_write_pulse(wr0);
                repeat (6) @(posedge sys_clk);
                check_write(wr0, addr_tab[i], data_tab[i]);
            end else begin
                conv_no = conv_no + 8'd1;
                drive_strobes(1'b1, 1'b0, 7'd0, 8'h00);
                if (op_tab[i] == OP_MIX) begin
                    // both strobes arrive once the reads have started
                    wait_samples(2);
                    drive_strobes(1'b1, 1'b1, addr_tab[i], data_tab[i]);
                end
                wait_frame_end(fr0);
                // the slipped-in write has to be on the bus before the frame ends
                if (op_tab[i] == OP_MIX) begin
                    check_write(wr0, addr_tab[i], data_tab[i]);
                end
                repeat (2) @(posedge sys_clk);
                check_frame(len_tab[i], conv_no);
                if (cnv_pulses != cnv0 + 1) begin
                    report_mismatch("adc_cnvst_n_o pulse count", cnv_pulses - cnv0, 1);
                end
            end
            repeat (4) @(posedge sys_clk);
        end

        $display("Table entries run: %0d, errors: %0d", NUM_ENTRIES, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hw
hw/adc_pif_pkg.sv
hw/pbus_if.sv
hw/pbus_arbiter.sv
hw/conv_sequencer.sv
hw/cfg_writer.sv
hw/adc_pif_top.sv
test/adc_model.sv
test/tb_adc_pif.sv
